/* verilog/cx_pkg.sv */
/*
  Shared types and constants for the custom-instruction dispatch unit.
  Imported by the interfaces and every stage of cx_unit.
*/
package cx_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int unsigned WORD_W  = 32;
  localparam int unsigned FUNC_W  = 25;
  localparam int unsigned REG_W   = 5;
  localparam int unsigned DELAY_W = 4;

  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [WORD_W-1:0]  insn_t;
  typedef logic [FUNC_W-1:0]  func_t;
  typedef logic [REG_W-1:0]   reg_idx_t;
  typedef logic [DELAY_W-1:0] delay_t;

  ////////////////////
  // Instruction fields
  ////////////////////

  localparam int unsigned OPC_LSB    = 0;
  localparam int unsigned OPC_MSB    = 6;
  localparam int unsigned RD_LSB     = 7;
  localparam int unsigned RD_MSB     = 11;
  localparam int unsigned OPTYPE_LSB = 12;
  localparam int unsigned OPTYPE_MSB = 13;
  localparam int unsigned FUNC_LSB   = 7;
  localparam int unsigned FUNC_MSB   = 31;
  localparam int unsigned DELAY_LSB  = 28;
  localparam int unsigned DELAY_MSB  = 31;

  // Major opcode of the custom-0 space
  localparam logic [6:0] OPC_CUSTOM0 = 7'b0001011;

  // What happens with the accelerator result
  typedef enum logic [1:0] {
    CX_OP_WRITE   = 2'd0,
    CX_OP_ACCUM   = 2'd1,
    CX_OP_NOWB    = 2'd2,
    CX_OP_ILLEGAL = 2'd3
  } cx_optype_e;

endpackage

/* verilog/cx_if.sv */
/*
  Stage-to-stage bundles of cx_unit.
  cx_issue_if runs from decode to execute, cx_done_if from execute to result.
*/
interface cx_issue_if import cx_pkg::*; ();
  logic       valid;
  insn_t      insn;
  reg_idx_t   rd;
  cx_optype_e optype;
  func_t      func;
  delay_t     delay;
  word_t      op_a;
  word_t      op_b;
  // Back from execute
  logic       busy;

  modport issue_src (output valid, insn, rd, optype, func, delay, op_a, op_b, input busy);
  modport issue_dst (input valid, insn, rd, optype, func, delay, op_a, op_b, output busy);
endinterface

interface cx_done_if import cx_pkg::*; ();
  logic       valid;
  reg_idx_t   rd;
  cx_optype_e optype;
  word_t      op_a;
  word_t      acc_result;

  modport done_src (output valid, rd, optype, op_a, acc_result);
  modport done_dst (input valid, rd, optype, op_a, acc_result);
endinterface

/* verilog/cx_decode.sv */
/*
  Decode stage of cx_unit.
  Takes the host instruction strobe while the unit is idle, recognises
  custom-0 opcodes and registers a one-cycle issue bundle for execute.
  Illegal operation types raise err_o instead of issuing.
*/
module cx_decode import cx_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,

  input  logic         insn_valid_i,
  input  insn_t        insn_i,
  input  word_t        op_a_i,
  input  word_t        op_b_i,

  output logic         err_o,

  cx_issue_if.issue_src issue
);

  logic       accept;
  logic       is_custom;
  logic       is_illegal;
  logic       issue_en;
  logic       valid_q;
  logic       err_q;
  reg_idx_t   rd;
  cx_optype_e optype;
  func_t      func;
  delay_t     delay;

  ////////////////////
  // Field split
  ////////////////////

  assign rd     = insn_i[RD_MSB:RD_LSB];
  assign optype = cx_optype_e'(insn_i[OPTYPE_MSB:OPTYPE_LSB]);
  assign func   = insn_i[FUNC_MSB:FUNC_LSB];
  assign delay  = insn_i[DELAY_MSB:DELAY_LSB];

  // Strobes during a busy span are dropped
  assign accept     = insn_valid_i & ~issue.busy;
  assign is_custom  = (insn_i[OPC_MSB:OPC_LSB] == OPC_CUSTOM0);
  assign is_illegal = (optype == CX_OP_ILLEGAL);
  assign issue_en   = accept & is_custom & ~is_illegal;

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      valid_q <= issue_en;
      err_q   <= accept & is_custom & is_illegal;
    end
  end

  // Payload stays put until the next issue, so execute can
  // present it to the accelerator for the whole span
  always_ff @(posedge clk_i) begin
    if (issue_en) begin
      issue.insn   <= insn_i;
      issue.rd     <= rd;
      issue.optype <= optype;
      issue.func   <= func;
      issue.delay  <= delay;
      issue.op_a   <= op_a_i;
      issue.op_b   <= op_b_i;
    end
  end

  assign issue.valid = valid_q;
  assign err_o       = err_q;

endmodule

/* verilog/cx_execute.sv */
/*
  Execute stage of cx_unit.
  Pulses the accelerator request in the issue cycle, counts out the
  instruction delay, samples the result and hands it to the result
  stage with a one-cycle done strobe. Reports busy back to decode.
*/
module cx_execute import cx_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,

  cx_issue_if.issue_dst issue,
  cx_done_if.done_src   done,

  // Accelerator side
  output logic          cx_req_valid_o,
  output func_t         cx_func_o,
  output insn_t         cx_insn_o,
  output word_t         cx_operand_a_o,
  output word_t         cx_operand_b_o,
  input  word_t         cx_result_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_DONE
  } cx_state_e;

  cx_state_e  state_q;
  cx_state_e  state_d;
  delay_t     cnt_q;
  logic       retire_q;
  logic       start;
  logic       sample;
  word_t      result_q;
  reg_idx_t   rd_q;
  cx_optype_e optype_q;
  word_t      op_a_q;

  assign start  = (state_q == ST_IDLE) & issue.valid;
  assign sample = (state_q == ST_WAIT) & (cnt_q == '0);

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (issue.valid) state_d = ST_WAIT;
      ST_WAIT: if (cnt_q == '0) state_d = ST_DONE;
      ST_DONE: state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= ST_IDLE;
      cnt_q    <= '0;
      retire_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      // Trailing cycle covers the writeback slot
      retire_q <= (state_q == ST_DONE);
      if (start) begin
        cnt_q <= issue.delay;
      end else if ((state_q == ST_WAIT) && (cnt_q != '0)) begin
        cnt_q <= cnt_q - delay_t'(1);
      end
    end
  end

  // Result plus the fields the writeback still needs
  always_ff @(posedge clk_i) begin
    if (sample) begin
      result_q <= cx_result_i;
      rd_q     <= issue.rd;
      optype_q <= issue.optype;
      op_a_q   <= issue.op_a;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  // Request payload is held by decode until the next issue
  assign cx_req_valid_o = start;
  assign cx_func_o      = issue.func;
  assign cx_insn_o      = issue.insn;
  assign cx_operand_a_o = issue.op_a;
  assign cx_operand_b_o = issue.op_b;

  assign done.valid      = (state_q == ST_DONE);
  assign done.rd         = rd_q;
  assign done.optype     = optype_q;
  assign done.op_a       = op_a_q;
  assign done.acc_result = result_q;

  assign issue.busy = issue.valid | (state_q != ST_IDLE) | retire_q;

endmodule

/* verilog/cx_result.sv */
/*
  Result stage of cx_unit.
  Forms the writeback value from the sampled accelerator result
  according to the operation type and registers it with a one-cycle
  valid. No-writeback instructions end here silently.
*/
module cx_result import cx_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,

  cx_done_if.done_dst done,

  output logic        wb_valid_o,
  output reg_idx_t    wb_rd_o,
  output word_t       wb_data_o
);

  logic  wb_en;
  logic  wb_valid_q;
  word_t wb_data;
  word_t wb_data_q;
  reg_idx_t wb_rd_q;

  ////////////////////
  // Merge
  ////////////////////

  always_comb begin
    wb_en   = 1'b0;
    wb_data = done.acc_result;
    case (done.optype)
      CX_OP_WRITE: begin
        wb_en = done.valid;
      end
      CX_OP_ACCUM: begin
        // Wraps modulo 2^32
        wb_en   = done.valid;
        wb_data = done.acc_result + done.op_a;
      end
      // Illegal never reaches this stage
      default: begin
        wb_en = 1'b0;
      end
    endcase
  end

  ////////////////////
  // Writeback register
  ////////////////////

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= wb_en;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_en) begin
      wb_rd_q   <= done.rd;
      wb_data_q <= wb_data;
    end
  end

  assign wb_valid_o = wb_valid_q;
  assign wb_rd_o    = wb_rd_q;
  assign wb_data_o  = wb_data_q;

endmodule

/* verilog/cx_unit.sv */
/*
  Custom-instruction dispatch unit.
  The host core hands over custom-0 instructions with both operands,
  the unit drives one accelerator request per instruction and writes
  the merged result back. Only one instruction is in flight at a time,
  new ones are taken while busy_o is low.
*/
module cx_unit import cx_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  // Host instruction strobe
  input  logic     insn_valid_i,
  input  insn_t    insn_i,
  input  word_t    op_a_i,
  input  word_t    op_b_i,

  // Accelerator request and result
  output logic     cx_req_valid_o,
  output func_t    cx_func_o,
  output insn_t    cx_insn_o,
  output word_t    cx_operand_a_o,
  output word_t    cx_operand_b_o,
  input  word_t    cx_result_i,

  // Register writeback
  output logic     wb_valid_o,
  output reg_idx_t wb_rd_o,
  output word_t    wb_data_o,

  // Status
  output logic     err_o,
  output logic     busy_o
);

  logic wb_valid;

  cx_issue_if issue_bus ();
  cx_done_if  done_bus ();

  ////////////////////
  // Stages
  ////////////////////

  cx_decode i_decode (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .insn_valid_i ( insn_valid_i ),
    .insn_i       ( insn_i       ),
    .op_a_i       ( op_a_i       ),
    .op_b_i       ( op_b_i       ),
    .err_o        ( err_o        ),
    .issue        ( issue_bus    )
  );

  cx_execute i_execute (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .issue          ( issue_bus      ),
    .done           ( done_bus       ),
    .cx_req_valid_o ( cx_req_valid_o ),
    .cx_func_o      ( cx_func_o      ),
    .cx_insn_o      ( cx_insn_o      ),
    .cx_operand_a_o ( cx_operand_a_o ),
    .cx_operand_b_o ( cx_operand_b_o ),
    .cx_result_i    ( cx_result_i    )
  );

  cx_result i_result (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .done       ( done_bus  ),
    .wb_valid_o ( wb_valid  ),
    .wb_rd_o    ( wb_rd_o   ),
    .wb_data_o  ( wb_data_o )
  );

  // Busy until the writeback slot has passed
  assign busy_o     = issue_bus.busy | wb_valid;
  assign wb_valid_o = wb_valid;

endmodule

/* bench/cx_checker.sv */
/*
  Port-level checker for cx_unit.
  Records each instruction strobe, predicts request, busy, error and
  writeback from the instruction fields and compares them every cycle.
*/
module cx_checker import cx_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        insn_valid_i,
  input  insn_t       insn_i,
  input  word_t       op_a_i,
  input  word_t       op_b_i,
  input  logic        cx_req_valid_i,
  input  func_t       cx_func_i,
  input  insn_t       cx_insn_i,
  input  word_t       cx_operand_a_i,
  input  word_t       cx_operand_b_i,
  input  logic        wb_valid_i,
  input  reg_idx_t    wb_rd_i,
  input  word_t       wb_data_i,
  input  logic        err_i,
  input  logic        busy_i,
  output int unsigned check_count_o,
  output int unsigned error_count_o
);

  int unsigned checks       = 0;
  int unsigned errors       = 0;
  int          cyc          = 0;
  int          t0           = -100;
  int          last         = -100;
  logic        armed        = 1'b0;
  logic        pend_legal   = 1'b0;
  logic        pend_illegal = 1'b0;
  logic        pend_wb      = 1'b0;
  insn_t       pend_insn;
  word_t       pend_a;
  word_t       pend_b;
  word_t       pend_data;

  assign check_count_o = checks;
  assign error_count_o = errors;

  // Accelerator behaviour as the bench models it
  function automatic word_t accel_result(word_t a, word_t b, func_t f);
    return (a ^ {b[18:0], b[31:19]}) + {f, 7'h35};
  endfunction

  function automatic word_t expected_wb(insn_t insn, word_t a, word_t b);
    word_t res;
    res = accel_result(a, b, insn[FUNC_MSB:FUNC_LSB]);
    if (cx_optype_e'(insn[OPTYPE_MSB:OPTYPE_LSB]) == CX_OP_ACCUM) begin
      res = res + a;
    end
    return res;
  endfunction

  task automatic compare(input string name, input logic [31:0] got,
                         input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("CHECK FAILED %s at cycle %0d: got 0x%08h, expected 0x%08h",
               name, cyc, got, exp);
    end
  endtask

  ////////////////////
  // Strobe tracking
  ////////////////////

  // Cycle index counts posedges, a strobe belongs to the cycle it ends
  always @(posedge clk_i) begin
    cx_optype_e optype;
    logic       custom;
    armed = rst_ni;
    if (!rst_ni) begin
      cyc          = 0;
      pend_legal   = 1'b0;
      pend_illegal = 1'b0;
      pend_wb      = 1'b0;
    end else begin
      if (insn_valid_i) begin
        custom       = (insn_i[OPC_MSB:OPC_LSB] == OPC_CUSTOM0);
        optype       = cx_optype_e'(insn_i[OPTYPE_MSB:OPTYPE_LSB]);
        pend_illegal = custom && (optype == CX_OP_ILLEGAL);
        pend_legal   = custom && (optype != CX_OP_ILLEGAL);
        pend_wb      = pend_legal && (optype == CX_OP_WRITE || optype == CX_OP_ACCUM);
        pend_insn    = insn_i;
        pend_a       = op_a_i;
        pend_b       = op_b_i;
        pend_data    = expected_wb(insn_i, op_a_i, op_b_i);
        t0           = cyc;
        last         = t0 + int'(insn_i[DELAY_MSB:DELAY_LSB]) + 4;
      end
      cyc = cyc + 1;
    end
  end

  ////////////////////
  // Comparison
  ////////////////////

  always @(negedge clk_i) begin
    logic exp_req;
    logic exp_busy;
    logic exp_wb;
    logic exp_err;
    if (armed) begin
      exp_req  = pend_legal && (cyc == t0 + 1);
      exp_busy = pend_legal && (cyc >= t0 + 1) && (cyc <= last);
      exp_wb   = pend_wb && (cyc == last);
      exp_err  = pend_illegal && (cyc == t0 + 1);
      compare("cx_req_valid_o", 32'(cx_req_valid_i), 32'(exp_req));
      compare("busy_o", 32'(busy_i), 32'(exp_busy));
      compare("wb_valid_o", 32'(wb_valid_i), 32'(exp_wb));
      compare("err_o", 32'(err_i), 32'(exp_err));
      // Request payload holds for the whole span
      if (exp_busy) begin
        compare("cx_func_o", 32'(cx_func_i), 32'(pend_insn[FUNC_MSB:FUNC_LSB]));
        compare("cx_insn_o", cx_insn_i, pend_insn);
        compare("cx_operand_a_o", cx_operand_a_i, pend_a);
        compare("cx_operand_b_o", cx_operand_b_i, pend_b);
      end
      if (exp_wb) begin
        compare("wb_rd_o", 32'(wb_rd_i), 32'(pend_insn[RD_MSB:RD_LSB]));
        compare("wb_data_o", wb_data_i, pend_data);
      end
    end
  end

endmodule

/* bench/tb_cx_unit.sv */
/*
  Testbench for cx_unit.
  Sends custom and other instructions from the host side, models the
  accelerator and leaves all comparing to cx_checker.
*/
module tb_cx_unit import cx_pkg::*; ();

  localparam int NUM_INSNS      = 120;
  // Longest span is D = 15 plus the idle gap, at most 24 cycles
  localparam int TIMEOUT_CYCLES = NUM_INSNS * 24 + 50;

  logic        clk         = 1'b0;
  logic        rst_n;
  logic        insn_valid;
  insn_t       insn;
  word_t       op_a;
  word_t       op_b;
  word_t       cx_result   = '0;
  logic        cx_req_valid;
  func_t       cx_func;
  insn_t       cx_insn;
  word_t       cx_operand_a;
  word_t       cx_operand_b;
  logic        wb_valid;
  reg_idx_t    wb_rd;
  word_t       wb_data;
  logic        err;
  logic        busy;
  int unsigned check_count;
  int unsigned error_count;
  integer      seed;
  int          cycle_count = 0;
  word_t       acc_a;
  word_t       acc_b;
  func_t       acc_func;
  logic        acc_pend    = 1'b0;

  always #20 clk = ~clk;

  cx_unit i_dut (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .insn_valid_i   ( insn_valid   ),
    .insn_i         ( insn         ),
    .op_a_i         ( op_a         ),
    .op_b_i         ( op_b         ),
    .cx_req_valid_o ( cx_req_valid ),
    .cx_func_o      ( cx_func      ),
    .cx_insn_o      ( cx_insn      ),
    .cx_operand_a_o ( cx_operand_a ),
    .cx_operand_b_o ( cx_operand_b ),
    .cx_result_i    ( cx_result    ),
    .wb_valid_o     ( wb_valid     ),
    .wb_rd_o        ( wb_rd        ),
    .wb_data_o      ( wb_data      ),
    .err_o          ( err          ),
    .busy_o         ( busy         )
  );

  cx_checker i_checker (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .insn_valid_i   ( insn_valid   ),
    .insn_i         ( insn         ),
    .op_a_i         ( op_a         ),
    .op_b_i         ( op_b         ),
    .cx_req_valid_i ( cx_req_valid ),
    .cx_func_i      ( cx_func      ),
    .cx_insn_i      ( cx_insn      ),
    .cx_operand_a_i ( cx_operand_a ),
    .cx_operand_b_i ( cx_operand_b ),
    .wb_valid_i     ( wb_valid     ),
    .wb_rd_i        ( wb_rd        ),
    .wb_data_i      ( wb_data      ),
    .err_i          ( err          ),
    .busy_i         ( busy         ),
    .check_count_o  ( check_count  ),
    .error_count_o  ( error_count  )
  );

  ////////////////////
  // Accelerator model
  ////////////////////

  function automatic word_t accel_mix(word_t a, word_t b, func_t f);
    return (a ^ {b[18:0], b[31:19]}) + {f, 7'h35};
  endfunction

  // Result appears in the cycle after the request and stays put
  // until the next one
  always @(negedge clk) begin
    acc_pend <= cx_req_valid;
    if (cx_req_valid) begin
      acc_a    <= cx_operand_a;
      acc_b    <= cx_operand_b;
      acc_func <= cx_func;
    end
    if (acc_pend) begin
      cx_result <= accel_mix(acc_a, acc_b, acc_func);
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic build_insn(input int idx, output insn_t insn_w);
    word_t      sel;
    logic [6:0] opc;
    insn_w = $random(seed);
    sel    = $random(seed);
    opc    = OPC_CUSTOM0;
    if (idx < 16) begin
      // Directed sweep of every delay over the three issuing types
      insn_w[DELAY_MSB:DELAY_LSB]   = idx[3:0];
      insn_w[OPTYPE_MSB:OPTYPE_LSB] = 2'(idx % 3);
    end else if (sel[2:0] == 3'd0) begin
      opc = sel[9:3];
      if (opc == OPC_CUSTOM0) begin
        opc = 7'b0110011;
      end
    end
    insn_w[OPC_MSB:OPC_LSB] = opc;
  endtask

  task automatic send_insn(input insn_t insn_w, input word_t a, input word_t b);
    int gap;
    insn_valid = 1'b1;
    insn       = insn_w;
    op_a       = a;
    op_b       = b;
    @(negedge clk);
    insn_valid = 1'b0;
    while (busy) begin
      @(negedge clk);
    end
    gap = 1 + ($random(seed) & 3);
    repeat (gap) @(negedge clk);
  endtask

  initial begin
    insn_t next_insn;
    word_t a;
    word_t b;
    rst_n      = 1'b0;
    insn_valid = 1'b0;
    insn       = '0;
    op_a       = '0;
    op_b       = '0;
    seed       = 32'he358_63bc;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    for (int i = 0; i < NUM_INSNS; i++) begin
      build_insn(i, next_insn);
      a = $random(seed);
      b = $random(seed);
      send_insn(next_insn, a, b);
    end
    repeat (4) @(negedge clk);
    $display("Instructions: %0d, checks: %0d, errors: %0d",
             NUM_INSNS, check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* compile.f */
verilog/cx_pkg.sv
verilog/cx_if.sv
verilog/cx_decode.sv
verilog/cx_execute.sv
verilog/cx_result.sv
verilog/cx_unit.sv
bench/cx_checker.sv
bench/tb_cx_unit.sv

/* Makefile */
TOP = tb_cx_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)
	verilator --lint-only verilog/cx_pkg.sv verilog/cx_if.sv verilog/cx_decode.sv \
		verilog/cx_execute.sv verilog/cx_result.sv verilog/cx_unit.sv --top-module cx_unit

sim:
	verilator --binary --timing -f compile.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -qx "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
